// ==== src/pid_consts.svh ====
`ifndef PID_CONSTS_SVH
`define PID_CONSTS_SVH

// ------------------------------
// Pipeline sizing
// ------------------------------
`define PID_N_CHAN      4       // Control channels
`define PID_N_SRC       8       // Sensor sources
`define PID_W_CHAN      2       // log2 of channel count
`define PID_W_SRC       3       // log2 of source count

// ------------------------------
// Datapath widths
// ------------------------------
`define PID_W_DIN       18      // Raw sample
`define PID_W_COMP      48      // Sums, products, deltas
`define PID_W_DOUT      32      // Accumulated output
`define PID_W_OPRND     16      // Gains, multipliers, shifts
`define PID_W_OS        4       // Oversample log2

// Config bus
`define PID_W_WR_ADDR   4
`define PID_W_WR_CHAN   4       // Channel or source select
`define PID_W_WR_DATA   32

`endif

// ==== src/pid_types_pkg.sv ====
`include "pid_consts.svh"

package pid_types_pkg;

    // Index types, unsigned
    typedef logic        [`PID_W_CHAN-1:0]  chan_t;
    typedef logic        [`PID_W_SRC-1:0]   src_t;

    // Signed datapath values
    typedef logic signed [`PID_W_DIN-1:0]   sample_t;
    typedef logic signed [`PID_W_COMP-1:0]  comp_t;
    typedef logic signed [`PID_W_DOUT-1:0]  dout_t;
    typedef logic signed [`PID_W_OPRND-1:0] oprnd_t;

    // ------------------------------
    // Beats between stages, dv high for one cycle
    // ------------------------------
    typedef struct packed {
        logic    dv;
        src_t    src;       // Originating sensor
        sample_t data;
    } src_beat_t;

    typedef struct packed {
        logic    dv;
        chan_t   chan;
        sample_t sample;
    } chan_beat_t;

    typedef struct packed {
        logic    dv;
        chan_t   chan;
        comp_t   comp;      // PID delta
    } comp_beat_t;

    typedef struct packed {
        logic    dv;
        chan_t   chan;
        dout_t   dout;      // Saturated channel output
    } out_beat_t;

endpackage

// ==== src/pid_cfg_pkg.sv ====
`include "pid_consts.svh"

package pid_cfg_pkg;

    // Register map
    typedef enum logic [`PID_W_WR_ADDR-1:0] {
        CFG_ROUTE    = 0,   // chan selects source, data[4] enable, low bits channel
        CFG_OS_LOG   = 1,   // Oversample log2
        CFG_KP       = 2,
        CFG_KI       = 3,
        CFG_KD       = 4,
        CFG_SETPOINT = 5,
        CFG_OUT_MULT = 6,   // Output gain
        CFG_OUT_RS   = 7    // Output right shift
    } cfg_addr_e;

    // ------------------------------
    // Write bus, one register per cycle while en high
    // ------------------------------
    typedef struct packed {
        logic                       en;
        cfg_addr_e                  addr;
        logic [`PID_W_WR_CHAN-1:0]  chan;   // Channel, or source for CFG_ROUTE
        logic [`PID_W_WR_DATA-1:0]  data;
    } cfg_wr_t;

endpackage

// ==== src/instr_dispatch.sv ====
`timescale 1ns/1ps
`include "pid_consts.svh"

module instr_dispatch (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  pid_types_pkg::src_beat_t   in_beat,
    input  pid_cfg_pkg::cfg_wr_t       cfg,
    output pid_types_pkg::chan_beat_t  out_beat
);
    import pid_types_pkg::*;
    import pid_cfg_pkg::*;

    localparam int ROUTE_EN_BIT = 4;   // Enable flag position in route data

    // One entry per source
    typedef struct packed {
        logic  en;
        chan_t chan;
    } route_t;

    route_t  route [`PID_N_SRC];
    route_t  hit;                      // Entry of the incoming source
    logic    cfg_wr;
    logic    dv_q;
    chan_t   chan_q;
    sample_t sample_q;

    assign hit    = route[in_beat.src];
    assign cfg_wr = cfg.en && (cfg.addr == CFG_ROUTE) && (cfg.chan < `PID_N_SRC);

    // Route table, all sources disabled out of reset
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PID_N_SRC; i++) begin
                route[i] <= '0;
            end
        end else if (cfg_wr) begin
            route[src_t'(cfg.chan)].en   <= cfg.data[ROUTE_EN_BIT];
            route[src_t'(cfg.chan)].chan <= cfg.data[`PID_W_CHAN-1:0];
        end
    end

    // Unrouted sources are dropped here
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) dv_q <= 1'b0;
        else         dv_q <= in_beat.dv && hit.en;
    end

    always_ff @(posedge clk_in) begin
        if (in_beat.dv) begin
            chan_q   <= hit.chan;
            sample_q <= in_beat.data;   // Value passes untouched
        end
    end

    assign out_beat = '{dv: dv_q, chan: chan_q, sample: sample_q};

    a_dv_known: assert property (@(posedge clk_in) disable iff (!arst_n)
        !$isunknown(out_beat.dv))
        else $error("dispatch dv unknown");

endmodule

// ==== src/oversample_filter.sv ====
`timescale 1ns/1ps
`include "pid_consts.svh"

module oversample_filter (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  pid_cfg_pkg::cfg_wr_t       cfg,
    input  pid_types_pkg::chan_beat_t  in_beat,
    output pid_types_pkg::chan_beat_t  out_beat
);
    import pid_types_pkg::*;
    import pid_cfg_pkg::*;

    // Counter must hold 2^os_log for the largest os_log
    localparam int W_CNT = (1 << `PID_W_OS);
    typedef logic [W_CNT-1:0] cnt_t;

    logic [`PID_W_OS-1:0] os_log [`PID_N_CHAN];
    comp_t                sum    [`PID_N_CHAN];   // Running group sum
    cnt_t                 cnt    [`PID_N_CHAN];   // Samples already in group

    logic    cfg_wr;
    chan_t   cfg_ch;
    comp_t   sum_nxt;
    cnt_t    cnt_nxt;
    cnt_t    grp_len;                            // 2^os_log of incoming channel
    logic    grp_done;
    sample_t avg;
    logic    dv_q;
    chan_t   chan_q;
    sample_t sample_q;

    assign cfg_wr = cfg.en && (cfg.addr == CFG_OS_LOG) && (cfg.chan < `PID_N_CHAN);
    assign cfg_ch = chan_t'(cfg.chan);

    // ------------------------------
    // Group arithmetic for the incoming channel
    // ------------------------------
    always_comb begin
        sum_nxt  = sum[in_beat.chan] + comp_t'(in_beat.sample);  // Sign extend
        cnt_nxt  = cnt[in_beat.chan] + cnt_t'(1);
        grp_len  = cnt_t'(1) << os_log[in_beat.chan];
        grp_done = (cnt_nxt == grp_len);
        avg      = sample_t'(sum_nxt >>> os_log[in_beat.chan]);
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                os_log[i] <= '0;
                sum[i]    <= '0;
                cnt[i]    <= '0;
            end
            dv_q <= 1'b0;
        end else begin
            // New group size restarts that channel
            if (cfg_wr) begin
                os_log[cfg_ch] <= cfg.data[`PID_W_OS-1:0];
                sum[cfg_ch]    <= '0;
                cnt[cfg_ch]    <= '0;
            end
            if (in_beat.dv) begin
                sum[in_beat.chan] <= grp_done ? '0 : sum_nxt;
                cnt[in_beat.chan] <= grp_done ? '0 : cnt_nxt;
            end
            dv_q <= in_beat.dv && grp_done;   // One beat per completed group
        end
    end

    always_ff @(posedge clk_in) begin
        if (in_beat.dv && grp_done) begin
            chan_q   <= in_beat.chan;
            sample_q <= avg;
        end
    end

    assign out_beat = '{dv: dv_q, chan: chan_q, sample: sample_q};

    a_cnt_bound: assert property (@(posedge clk_in) disable iff (!arst_n)
        in_beat.dv |-> (cnt[in_beat.chan] < grp_len))
        else $error("oversample count overrun on channel %0d", in_beat.chan);

endmodule

// ==== src/pid_filter.sv ====
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_filter (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  pid_cfg_pkg::cfg_wr_t       cfg,
    input  pid_types_pkg::chan_beat_t  in_beat,
    output pid_types_pkg::comp_beat_t  out_beat
);
    import pid_types_pkg::*;
    import pid_cfg_pkg::*;

    // Setpoint minus sample needs one extra bit
    typedef logic signed [`PID_W_DIN:0] err_t;

    // Per-channel coefficients
    oprnd_t  kp       [`PID_N_CHAN];
    oprnd_t  ki       [`PID_N_CHAN];
    oprnd_t  kd       [`PID_N_CHAN];
    sample_t setpoint [`PID_N_CHAN];

    // Error history
    err_t    e1_mem   [`PID_N_CHAN];   // e[n-1]
    err_t    e2_mem   [`PID_N_CHAN];   // e[n-2]

    logic    cfg_ok;
    chan_t   cfg_ch;
    err_t    e_nxt;

    // Stage one registers
    logic    dv_s1;
    chan_t   chan_s1;
    err_t    e_s1;
    err_t    e1_s1;
    err_t    e2_s1;

    // Stage two
    comp_t   ce;
    comp_t   ce1;
    comp_t   ce2;
    comp_t   delta;
    logic    dv_s2;
    chan_t   chan_s2;
    comp_t   delta_s2;

    assign cfg_ok = cfg.en && (cfg.chan < `PID_N_CHAN);
    assign cfg_ch = chan_t'(cfg.chan);
    assign e_nxt  = err_t'(setpoint[in_beat.chan]) - err_t'(in_beat.sample);

    // ------------------------------
    // Control state and history
    // ------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                kp[i]       <= '0;
                ki[i]       <= '0;
                kd[i]       <= '0;
                setpoint[i] <= '0;
                e1_mem[i]   <= '0;
                e2_mem[i]   <= '0;
            end
            dv_s1 <= 1'b0;
            dv_s2 <= 1'b0;
        end else begin
            if (cfg_ok) begin
                case (cfg.addr)
                    CFG_KP:       kp[cfg_ch]       <= cfg.data[`PID_W_OPRND-1:0];
                    CFG_KI:       ki[cfg_ch]       <= cfg.data[`PID_W_OPRND-1:0];
                    CFG_KD:       kd[cfg_ch]       <= cfg.data[`PID_W_OPRND-1:0];
                    CFG_SETPOINT: setpoint[cfg_ch] <= cfg.data[`PID_W_DIN-1:0];
                    default: ;
                endcase
            end
            // Shift history now so a following beat of this channel sees it
            if (in_beat.dv) begin
                e1_mem[in_beat.chan] <= e_nxt;
                e2_mem[in_beat.chan] <= e1_mem[in_beat.chan];
            end
            dv_s1 <= in_beat.dv;
            dv_s2 <= dv_s1;
        end
    end

    // Velocity form kp*(e-e1) + ki*e + kd*(e-2e1+e2)
    always_comb begin
        ce    = comp_t'(e_s1);
        ce1   = comp_t'(e1_s1);
        ce2   = comp_t'(e2_s1);
        delta = comp_t'(kp[chan_s1]) * (ce - ce1)
              + comp_t'(ki[chan_s1]) * ce
              + comp_t'(kd[chan_s1]) * (ce - (ce1 <<< 1) + ce2);
    end

    // Payload pipe
    always_ff @(posedge clk_in) begin
        chan_s1  <= in_beat.chan;
        e_s1     <= e_nxt;
        e1_s1    <= e1_mem[in_beat.chan];
        e2_s1    <= e2_mem[in_beat.chan];
        chan_s2  <= chan_s1;
        delta_s2 <= delta;
    end

    assign out_beat = '{dv: dv_s2, chan: chan_s2, comp: delta_s2};

    a_latency: assert property (@(posedge clk_in) disable iff (!arst_n)
        in_beat.dv |-> ##2 out_beat.dv)
        else $error("pid output missing two cycles after input");

endmodule

// ==== src/output_filter.sv ====
`timescale 1ns/1ps
`include "pid_consts.svh"

module output_filter (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  pid_cfg_pkg::cfg_wr_t       cfg,
    input  pid_types_pkg::comp_beat_t  in_beat,
    output pid_types_pkg::out_beat_t   out_beat
);
    import pid_types_pkg::*;
    import pid_cfg_pkg::*;

    // One guard bit over comp_t for the accumulate
    typedef logic signed [`PID_W_COMP:0] acc_t;

    localparam dout_t DOUT_MAX = {1'b0, {(`PID_W_DOUT-1){1'b1}}};
    localparam dout_t DOUT_MIN = {1'b1, {(`PID_W_DOUT-1){1'b0}}};

    oprnd_t                  mult    [`PID_N_CHAN];
    logic [`PID_W_OPRND-1:0] rs      [`PID_N_CHAN];   // Unsigned shift
    dout_t                   out_mem [`PID_N_CHAN];   // Last output per channel

    logic  cfg_ok;
    chan_t cfg_ch;
    comp_t scaled;
    logic  dv_s1;
    chan_t chan_s1;
    comp_t scaled_s1;
    acc_t  acc;
    dout_t sat;
    logic  dv_s2;
    chan_t chan_s2;
    dout_t dout_s2;

    assign cfg_ok = cfg.en && (cfg.chan < `PID_N_CHAN);
    assign cfg_ch = chan_t'(cfg.chan);

    // ------------------------------
    // Stage one, scale
    // ------------------------------
    assign scaled = (in_beat.comp * comp_t'(mult[in_beat.chan])) >>> rs[in_beat.chan];

    // Stage two, accumulate and clamp
    always_comb begin
        acc = acc_t'(out_mem[chan_s1]) + acc_t'(scaled_s1);
        if (acc > acc_t'(DOUT_MAX))      sat = DOUT_MAX;
        else if (acc < acc_t'(DOUT_MIN)) sat = DOUT_MIN;
        else                             sat = dout_t'(acc);
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                mult[i]    <= '0;
                rs[i]      <= '0;
                out_mem[i] <= '0;
            end
            dv_s1 <= 1'b0;
            dv_s2 <= 1'b0;
        end else begin
            if (cfg_ok && cfg.addr == CFG_OUT_MULT) mult[cfg_ch] <= cfg.data[`PID_W_OPRND-1:0];
            if (cfg_ok && cfg.addr == CFG_OUT_RS)   rs[cfg_ch]   <= cfg.data[`PID_W_OPRND-1:0];
            if (dv_s1) out_mem[chan_s1] <= sat;   // Write back clamped value
            dv_s1 <= in_beat.dv;
            dv_s2 <= dv_s1;
        end
    end

    always_ff @(posedge clk_in) begin
        chan_s1   <= in_beat.chan;
        scaled_s1 <= scaled;
        chan_s2   <= chan_s1;
        dout_s2   <= sat;
    end

    assign out_beat = '{dv: dv_s2, chan: chan_s2, dout: dout_s2};

    a_chan_range: assert property (@(posedge clk_in) disable iff (!arst_n)
        out_beat.dv |-> (out_beat.chan < `PID_N_CHAN))
        else $error("output channel %0d out of range", out_beat.chan);

endmodule

// ==== src/pid_pipeline.sv ====
`timescale 1ns/1ps

module pid_pipeline (
    input  logic                      clk_in,
    input  logic                      arst_n,
    input  pid_types_pkg::src_beat_t  in_beat,
    input  pid_cfg_pkg::cfg_wr_t      cfg,
    output pid_types_pkg::out_beat_t  out_beat
);
    import pid_types_pkg::*;

    chan_beat_t idp_beat;   // Routed samples
    chan_beat_t osf_beat;   // Group averages
    comp_beat_t pid_beat;   // Correction deltas

    // ------------------------------
    // Stage chain, 1+1+2+2 cycles
    // ------------------------------
    instr_dispatch idp (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .in_beat  (in_beat),
        .cfg      (cfg),
        .out_beat (idp_beat)
    );

    oversample_filter osf (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .in_beat  (idp_beat),
        .out_beat (osf_beat)
    );

    pid_filter pid (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .in_beat  (osf_beat),
        .out_beat (pid_beat)
    );

    output_filter opf (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .in_beat  (pid_beat),
        .out_beat (out_beat)   // Top output straight from the last stage
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,   // Full clock period
    parameter int RESET_CYCLES = 10
) (
    output logic clk_in,
    output logic arst_n
);

    initial clk_in = 1'b0;
    always #(PERIOD_NS / 2) clk_in = ~clk_in;

    // Reset low from time zero, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
    end

endmodule

// ==== tb/tb_pid_pipeline.sv ====
`timescale 1ns/1ps
`include "pid_consts.svh"

module tb_pid_pipeline;
    import pid_types_pkg::*;
    import pid_cfg_pkg::*;

    localparam int LATENCY = 6;   // Group-completing input to output

    // Per-channel setup, ch0 general, ch1 averaging, ch2 high gain, ch3 merged
    localparam int OS_TAB   [`PID_N_CHAN] = '{0, 2, 0, 0};
    localparam int KP_TAB   [`PID_N_CHAN] = '{3, 1, 0, 2};
    localparam int KI_TAB   [`PID_N_CHAN] = '{2, 1, 1000, 0};
    localparam int KD_TAB   [`PID_N_CHAN] = '{1, 0, 0, 1};
    localparam int SP_TAB   [`PID_N_CHAN] = '{100, -50, 0, 0};
    localparam int MULT_TAB [`PID_N_CHAN] = '{3, 1, 100, 5};
    localparam int RS_TAB   [`PID_N_CHAN] = '{1, 0, 0, 2};
    localparam int BURST_SRC [4]          = '{0, 3, 4, 2};

    // One table row, config write or sample, plus model result
    typedef struct packed {
        logic                      is_cfg;
        cfg_addr_e                 addr;
        logic [`PID_W_WR_CHAN-1:0] chan;
        logic [`PID_W_WR_DATA-1:0] data;
        src_t                      src;
        sample_t                   value;
        logic                      exp_valid;   // Row completes a group
        chan_t                     exp_chan;
        dout_t                     exp_dout;
    } row_t;

    typedef struct packed {
        chan_t chan;
        dout_t dout;
        int    launch;   // Edge that put the input on the bus
    } exp_t;

    logic       clk_in;
    logic       arst_n;
    src_beat_t  in_beat;
    cfg_wr_t    cfg;
    out_beat_t  out_beat;

    row_t   table_q [$];
    exp_t   pending [$];   // In input order
    exp_t   head;
    integer seed      = 97;
    int     cycle     = 0;
    int     limit     = 0;
    int     n_value   = 0;
    int     n_latency = 0;
    int     n_extra   = 0;
    int     n_reset   = 0;
    int     n_missing = 0;

    tb_clock_gen clk_gen (.clk_in(clk_in), .arst_n(arst_n));

    pid_pipeline UUT (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .in_beat  (in_beat),
        .cfg      (cfg),
        .out_beat (out_beat)
    );

    always @(posedge clk_in) cycle <= cycle + 1;

    // ------------------------------
    // Table construction
    // ------------------------------
    function automatic sample_t random_sample();
        return sample_t'($random(seed) % 4096);   // Within +-2^12
    endfunction

    task automatic add_cfg(input cfg_addr_e addr, input int chan, input logic [31:0] data);
        row_t r;
        r        = '0;
        r.is_cfg = 1'b1;
        r.addr   = addr;
        r.chan   = chan[`PID_W_WR_CHAN-1:0];
        r.data   = data;
        table_q.push_back(r);
    endtask

    task automatic add_sample(input int src, input sample_t value);
        row_t r;
        r       = '0;
        r.src   = src_t'(src);
        r.value = value;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        add_cfg(CFG_ROUTE, 0, 32'h10);   // Bit 4 enables
        add_cfg(CFG_ROUTE, 1, 32'h11);
        add_cfg(CFG_ROUTE, 2, 32'h12);
        add_cfg(CFG_ROUTE, 3, 32'h13);
        add_cfg(CFG_ROUTE, 4, 32'h13);   // Second source into ch3
        add_cfg(CFG_ROUTE, 6, 32'h01);   // Channel set, enable off
        for (int c = 0; c < `PID_N_CHAN; c++) begin
            add_cfg(CFG_OS_LOG, c, OS_TAB[c]);
            add_cfg(CFG_KP, c, KP_TAB[c]);
            add_cfg(CFG_KI, c, KI_TAB[c]);
            add_cfg(CFG_KD, c, KD_TAB[c]);
            add_cfg(CFG_SETPOINT, c, SP_TAB[c]);
            add_cfg(CFG_OUT_MULT, c, MULT_TAB[c]);
            add_cfg(CFG_OUT_RS, c, RS_TAB[c]);
        end
        add_sample(5, random_sample());   // Never routed
        add_sample(6, random_sample());   // Routed but disabled
        add_sample(0, random_sample());
        add_sample(3, random_sample());
        add_sample(4, random_sample());
        // Groups of 4 on ch1 interleaved with ch0
        for (int i = 0; i < 8; i++) begin
            add_sample(1, random_sample());
            add_sample(0, random_sample());
        end
        repeat (6) add_sample(0, random_sample());   // History back to back
        // Clamp high, stay, clamp low, then leave the limit
        add_sample(2, sample_t'(-131072));
        add_sample(2, sample_t'(-131072));
        add_sample(2, sample_t'(131071));
        add_sample(2, sample_t'(-1000));
        add_sample(2, sample_t'(500));
        for (int i = 0; i < 16; i++) begin
            add_sample(BURST_SRC[i % 4], random_sample());
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic longint saturate(input longint v);
        if (v > 64'sd2147483647) return 64'sd2147483647;
        if (v < -64'sd2147483648) return -64'sd2147483648;
        return v;
    endfunction

    task automatic run_model();
        logic   route_en [`PID_N_SRC];
        int     route_ch [`PID_N_SRC];
        int     os_log   [`PID_N_CHAN];
        int     os_cnt   [`PID_N_CHAN];
        longint os_sum   [`PID_N_CHAN];
        longint kp       [`PID_N_CHAN];
        longint ki       [`PID_N_CHAN];
        longint kd       [`PID_N_CHAN];
        longint sp       [`PID_N_CHAN];
        longint mult     [`PID_N_CHAN];
        int     rs       [`PID_N_CHAN];
        longint e1       [`PID_N_CHAN];
        longint e2       [`PID_N_CHAN];
        longint acc      [`PID_N_CHAN];
        longint e;
        longint delta;
        int     ch;
        row_t   r;
        for (int s = 0; s < `PID_N_SRC; s++) begin
            route_en[s] = 1'b0;
            route_ch[s] = 0;
        end
        for (int c = 0; c < `PID_N_CHAN; c++) begin   // Everything zero out of reset
            os_log[c] = 0;
            os_cnt[c] = 0;
            os_sum[c] = 0;
            rs[c]     = 0;
            kp[c]     = 0;
            ki[c]     = 0;
            kd[c]     = 0;
            sp[c]     = 0;
            mult[c]   = 0;
            e1[c]     = 0;
            e2[c]     = 0;
            acc[c]    = 0;
        end
        foreach (table_q[i]) begin
            r  = table_q[i];
            ch = int'(r.chan[`PID_W_CHAN-1:0]);
            if (r.is_cfg) begin
                case (r.addr)
                    CFG_ROUTE: begin
                        route_en[r.chan[`PID_W_SRC-1:0]] = r.data[4];
                        route_ch[r.chan[`PID_W_SRC-1:0]] = int'(r.data[`PID_W_CHAN-1:0]);
                    end
                    CFG_OS_LOG: begin
                        os_log[ch] = int'(r.data[`PID_W_OS-1:0]);
                        os_sum[ch] = 0;
                        os_cnt[ch] = 0;
                    end
                    CFG_KP:       kp[ch]   = longint'($signed(r.data[15:0]));
                    CFG_KI:       ki[ch]   = longint'($signed(r.data[15:0]));
                    CFG_KD:       kd[ch]   = longint'($signed(r.data[15:0]));
                    CFG_SETPOINT: sp[ch]   = longint'($signed(r.data[17:0]));
                    CFG_OUT_MULT: mult[ch] = longint'($signed(r.data[15:0]));
                    CFG_OUT_RS:   rs[ch]   = int'(r.data[15:0]);
                    default: ;
                endcase
            end else if (route_en[r.src]) begin
                ch         = route_ch[r.src];
                os_sum[ch] = os_sum[ch] + longint'(r.value);
                os_cnt[ch] = os_cnt[ch] + 1;
                if (os_cnt[ch] == (1 << os_log[ch])) begin   // Group complete
                    e          = sp[ch] - (os_sum[ch] >>> os_log[ch]);
                    os_sum[ch] = 0;
                    os_cnt[ch] = 0;
                    delta = kp[ch] * (e - e1[ch]) + ki[ch] * e
                          + kd[ch] * (e - 2 * e1[ch] + e2[ch]);
                    e2[ch]  = e1[ch];
                    e1[ch]  = e;
                    acc[ch] = saturate(acc[ch] + ((delta * mult[ch]) >>> rs[ch]));
                    table_q[i].exp_valid = 1'b1;
                    table_q[i].exp_chan  = chan_t'(ch);
                    table_q[i].exp_dout  = dout_t'(acc[ch]);
                end
            end
        end
    endtask

    // ------------------------------
    // Driving
    // ------------------------------
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_in);
            in_beat <= '0;
            cfg     <= '0;
        end
    endtask

    task automatic drive_row(input row_t r);
        exp_t x;
        @(posedge clk_in);
        if (r.is_cfg) begin
            cfg     <= '{en: 1'b1, addr: r.addr, chan: r.chan, data: r.data};
            in_beat <= '0;
            idle(1);   // Bus idle after each write
        end else begin
            cfg     <= '0;
            in_beat <= '{dv: 1'b1, src: r.src, data: r.value};
            if (r.exp_valid) begin
                x = '{chan: r.exp_chan, dout: r.exp_dout, launch: cycle + 1};
                pending.push_back(x);
            end
        end
    endtask

    task automatic finish_run(input logic timed_out);
        n_missing = pending.size();
        assert (n_missing == 0)
            else $display("%0d expected outputs never appeared", n_missing);
        $display("Errors: value %0d, latency %0d, unexpected %0d, reset %0d, missing %0d",
                 n_value, n_latency, n_extra, n_reset, n_missing);
        if (!timed_out && (n_value + n_latency + n_extra + n_reset + n_missing) == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        in_beat = '0;
        cfg     = '0;
        build_table();
        run_model();
        limit = table_q.size() + 100;
        wait (arst_n === 1'b1);
        foreach (table_q[i]) begin
            if (i > 0 && table_q[i-1].is_cfg && !table_q[i].is_cfg) idle(4);
            drive_row(table_q[i]);
        end
        idle(1);
        while (pending.size() != 0) @(posedge clk_in);
        idle(8);   // Catch any stray late output
        finish_run(1'b0);
    end

    // ------------------------------
    // Output checker, sampled mid-cycle
    // ------------------------------
    always @(negedge clk_in) begin
        if (!arst_n) begin
            assert (out_beat.dv === 1'b0)
                else begin
                    n_reset++;
                    $display("Output strobe active during reset at %0t", $time);
                end
        end else if (out_beat.dv !== 1'b0) begin
            if (pending.size() == 0) begin
                n_extra++;
                $display("Unexpected output on channel %0d at %0t, nothing was pending",
                         out_beat.chan, $time);
            end else begin
                head = pending.pop_front();
                assert (out_beat.chan == head.chan && out_beat.dout == head.dout)
                    else begin
                        n_value++;
                        $display("CHECK FAILED at %0t: channel %0d got %0d, expected ch %0d %0d",
                                 $time, out_beat.chan, out_beat.dout, head.chan, head.dout);
                    end
                assert (cycle - head.launch == LATENCY)
                    else begin
                        n_latency++;
                        $display("CHECK FAILED at %0t: channel %0d latency %0d, expected %0d",
                                 $time, out_beat.chan, cycle - head.launch, LATENCY);
                    end
            end
        end
    end

    // Hang guard
    initial begin
        wait (limit > 0);
        wait (cycle >= limit);
        $display("Run stopped by timeout after %0d cycles", cycle);
        finish_run(1'b1);
    end

endmodule

// ==== sources.f ====
+incdir+src
src/pid_types_pkg.sv
src/pid_cfg_pkg.sv
src/instr_dispatch.sv
src/oversample_filter.sv
src/pid_filter.sv
src/output_filter.sv
src/pid_pipeline.sv
tb/tb_clock_gen.sv
tb/tb_pid_pipeline.sv

// ==== Makefile ====
# Verilator simulation of the PID pipeline

VERILATOR ?= verilator
TOP       ?= tb_pid_pipeline
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
